/* wm_pkg.sv */
package wm_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Array geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int WM_WIDTH  = 16;              // Lanes per row.
    localparam int WM_DEPTH  = 8;               // Rows.
    localparam int WM_BITW   = 8;               // Bits per weight.
    localparam int WM_WIDX_W = $clog2(WM_WIDTH);
    localparam int WM_DIDX_W = $clog2(WM_DEPTH);
    localparam int WM_DATA_W = 2 * WM_WIDTH;    // One 2-bit step per lane.

    // Signed limits used when INCR saturates.
    localparam int WEIGHT_MAX = (2 ** (WM_BITW - 1)) - 1;
    localparam int WEIGHT_MIN = -(2 ** (WM_BITW - 1));

    localparam int DROP_CNT_W = 16;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Command types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        OP_LOAD = 2'd0,
        OP_INCR = 2'd1,
        OP_READ = 2'd2
    } wm_op_e;

    typedef logic signed [WM_BITW-1:0] weight_t;
    typedef logic signed [1:0]         step_t;

    typedef struct packed {
        wm_op_e                 op;
        logic [WM_WIDX_W-1:0]   w_idx;
        logic [WM_DIDX_W-1:0]   d_idx;
        logic [WM_DATA_W-1:0]   data;   // LOAD uses the low bits, INCR all of it.
    } wm_cmd_t;

endpackage

/* wm_cmd_if.sv */
`timescale 1ns/1ps

interface wm_cmd_if;

    import wm_pkg::*;

    logic    valid;
    logic    ready;
    wm_cmd_t cmd;

    // Front end side.
    modport src (
        output valid,
        output cmd,
        input  ready
    );

    // Weight bank side.
    modport dst (
        input  valid,
        input  cmd,
        output ready
    );

endinterface

/* wm_cmd_front.sv */
`timescale 1ns/1ps

module wm_cmd_front (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cmd_valid,
    output logic                           cmd_ready,
    input  wm_pkg::wm_op_e                 cmd_op,
    input  logic [wm_pkg::WM_WIDX_W-1:0]   cmd_w_idx,
    input  logic [wm_pkg::WM_DIDX_W-1:0]   cmd_d_idx,
    input  logic [wm_pkg::WM_DATA_W-1:0]   cmd_data,
    input  logic [wm_pkg::WM_DEPTH-1:0]    lock_mask,
    output logic [wm_pkg::DROP_CNT_W-1:0]  drop_count,
    wm_cmd_if.src                          cmd_o
);

    import wm_pkg::*;

    typedef enum logic {
        EMPTY,
        FULL
    } state_e;

    state_e  state;
    state_e  state_nxt;
    wm_cmd_t cmd_q;
    logic    accept;
    logic    locked;
    logic    keep;
    logic    drop_pend;

    assign cmd_ready = (state == EMPTY) || cmd_o.ready;
    assign accept    = cmd_valid && cmd_ready;
    assign locked    = lock_mask[cmd_d_idx] && (cmd_op != OP_READ);  // Reads pass a lock.
    assign keep      = accept && !locked;

    assign cmd_o.valid = (state == FULL);
    assign cmd_o.cmd   = cmd_q;

    always_comb begin
        state_nxt = state;
        case (state)
            EMPTY: if (keep) state_nxt = FULL;
            FULL:  if (cmd_o.ready) state_nxt = keep ? FULL : EMPTY;
            default: state_nxt = EMPTY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= EMPTY;
            drop_pend  <= 1'b0;
            drop_count <= '0;
        end else begin
            state     <= state_nxt;
            drop_pend <= accept && locked;
            if (drop_pend && (drop_count != '1)) begin
                drop_count <= drop_count + 1'b1;   // Saturates at all ones.
            end
        end
    end

    // Buffer payload.
    always_ff @(posedge clk) begin
        if (keep) begin
            cmd_q.op    <= cmd_op;
            cmd_q.w_idx <= cmd_w_idx;
            cmd_q.d_idx <= cmd_d_idx;
            cmd_q.data  <= cmd_data;
        end
    end

    a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_o.valid && !cmd_o.ready |=> $stable(cmd_o.cmd));

endmodule

/* wm_mode_regs.sv */
`timescale 1ns/1ps

module wm_mode_regs (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cfg_we,
    input  logic                         cfg_sat,
    input  logic [wm_pkg::WM_DEPTH-1:0]  cfg_lock,
    output logic                         sat_en,
    output logic [wm_pkg::WM_DEPTH-1:0]  lock_mask
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Mode and lock registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sat_en    <= 1'b0;         // Wrap mode.
            lock_mask <= '0;           // All rows writable.
        end else if (cfg_we) begin
            sat_en    <= cfg_sat;
            lock_mask <= cfg_lock;
        end
    end

endmodule

/* weight_update_alu.sv */
`timescale 1ns/1ps

module weight_update_alu (
    input  wm_pkg::wm_op_e   op,
    input  wm_pkg::weight_t  cur,
    input  wm_pkg::weight_t  load_val,
    input  wm_pkg::step_t    step,
    input  logic             sat_en,
    output wm_pkg::weight_t  nxt
);

    import wm_pkg::*;

    logic signed [WM_BITW:0] sum;   // One guard bit for overflow.

    assign sum = cur + step;

    always_comb begin
        case (op)
            OP_LOAD: nxt = load_val;
            OP_INCR: begin
                if (sat_en && (sum > WEIGHT_MAX)) begin
                    nxt = weight_t'(WEIGHT_MAX);
                end else if (sat_en && (sum < WEIGHT_MIN)) begin
                    nxt = weight_t'(WEIGHT_MIN);
                end else begin
                    nxt = sum[WM_BITW-1:0];     // Two's complement wrap.
                end
            end
            default: nxt = cur;
        endcase
    end

endmodule

/* weight_bank.sv */
`timescale 1ns/1ps

module weight_bank (
    input  logic                          clk,
    input  logic                          rst_n,
    wm_cmd_if.dst                         cmd_i,
    input  logic                          sat_en,
    output logic                          rsp_valid,
    input  logic                          rsp_ready,
    output wm_pkg::weight_t               rsp_data,
    output logic [wm_pkg::WM_WIDX_W-1:0]  rsp_w_idx,
    output logic [wm_pkg::WM_DIDX_W-1:0]  rsp_d_idx
);

    import wm_pkg::*;

    weight_t mem [WM_DEPTH][WM_WIDTH];
    weight_t cur_row [WM_WIDTH];
    weight_t nxt_row [WM_WIDTH];
    logic    xfer;
    logic    stalled;

    assign stalled     = rsp_valid && !rsp_ready;
    assign cmd_i.ready = !stalled;
    assign xfer        = cmd_i.valid && cmd_i.ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Per-lane update logic
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar gi = 0; gi < WM_WIDTH; gi++) begin : g_lane
        assign cur_row[gi] = mem[cmd_i.cmd.d_idx][gi];

        weight_update_alu u_alu (
            .op       (cmd_i.cmd.op),
            .cur      (cur_row[gi]),
            .load_val (cmd_i.cmd.data[WM_BITW-1:0]),
            .step     (cmd_i.cmd.data[2*gi+1:2*gi]),   // Lane step from the packed word.
            .sat_en   (sat_en),
            .nxt      (nxt_row[gi])
        );
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Weight array
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < WM_DEPTH; r++) begin
                for (int l = 0; l < WM_WIDTH; l++) begin
                    mem[r][l] <= '0;
                end
            end
        end else if (xfer) begin
            case (cmd_i.cmd.op)
                OP_LOAD: begin
                    mem[cmd_i.cmd.d_idx][cmd_i.cmd.w_idx] <= nxt_row[cmd_i.cmd.w_idx];
                end
                OP_INCR: begin
                    for (int l = 0; l < WM_WIDTH; l++) begin
                        mem[cmd_i.cmd.d_idx][l] <= nxt_row[l];   // Whole row at once.
                    end
                end
                default: ;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read response register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (xfer && (cmd_i.cmd.op == OP_READ)) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer && (cmd_i.cmd.op == OP_READ)) begin
            rsp_data  <= cur_row[cmd_i.cmd.w_idx];
            rsp_w_idx <= cmd_i.cmd.w_idx;
            rsp_d_idx <= cmd_i.cmd.d_idx;
        end
    end

    a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stalled |=> rsp_valid && $stable(rsp_data)
                    && $stable(rsp_w_idx) && $stable(rsp_d_idx));

    // A command offered during a stall is still offered unchanged, so none is consumed.
    a_no_xfer_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stalled && cmd_i.valid |=> cmd_i.valid && $stable(cmd_i.cmd));

endmodule

/* wm_top.sv */
`timescale 1ns/1ps

module wm_top (
    input  logic                           clk,
    input  logic                           rst_n,

    // Command channel.
    input  logic                           cmd_valid,
    output logic                           cmd_ready,
    input  wm_pkg::wm_op_e                 cmd_op,
    input  logic [wm_pkg::WM_WIDX_W-1:0]   cmd_w_idx,
    input  logic [wm_pkg::WM_DIDX_W-1:0]   cmd_d_idx,
    input  logic [wm_pkg::WM_DATA_W-1:0]   cmd_data,

    // Response channel.
    output logic                           rsp_valid,
    input  logic                           rsp_ready,
    output wm_pkg::weight_t                rsp_data,
    output logic [wm_pkg::WM_WIDX_W-1:0]   rsp_w_idx,
    output logic [wm_pkg::WM_DIDX_W-1:0]   rsp_d_idx,

    // Configuration.
    input  logic                           cfg_we,
    input  logic                           cfg_sat,
    input  logic [wm_pkg::WM_DEPTH-1:0]    cfg_lock,

    output logic [wm_pkg::DROP_CNT_W-1:0]  drop_count
);

    logic                        sat_en;
    logic [wm_pkg::WM_DEPTH-1:0] lock_mask;

    wm_cmd_if cmd_bus ();

    wm_cmd_front u_front (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_op     (cmd_op),
        .cmd_w_idx  (cmd_w_idx),
        .cmd_d_idx  (cmd_d_idx),
        .cmd_data   (cmd_data),
        .lock_mask  (lock_mask),
        .drop_count (drop_count),
        .cmd_o      (cmd_bus.src)
    );

    wm_mode_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_sat   (cfg_sat),
        .cfg_lock  (cfg_lock),
        .sat_en    (sat_en),
        .lock_mask (lock_mask)
    );

    weight_bank u_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_i     (cmd_bus.dst),
        .sat_en    (sat_en),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data),
        .rsp_w_idx (rsp_w_idx),
        .rsp_d_idx (rsp_d_idx)
    );

endmodule

/* wm_tb_model.svh */
`ifndef WM_TB_MODEL_SVH
`define WM_TB_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of the weight store
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
typedef struct packed {
    weight_t              data;
    logic [WM_WIDX_W-1:0] w_idx;
    logic [WM_DIDX_W-1:0] d_idx;
} exp_rsp_t;

weight_t             model_mem [WM_DEPTH][WM_WIDTH];
logic                model_sat;
logic [WM_DEPTH-1:0] model_lock;
int                  model_drops;
exp_rsp_t            exp_q [$];                 // Responses in command order.

// Signed value of the two step bits that belong to one lane.
function automatic int step_of(logic [WM_DATA_W-1:0] data, int lane);
    logic [1:0] bits;
    bits = data[2*lane +: 2];
    return bits[1] ? int'(bits) - 4 : int'(bits);
endfunction

function automatic weight_t incr_value(weight_t cur, int step, logic sat);
    int s;
    int lim;
    lim = 1 << (WM_BITW - 1);
    s   = int'(cur) + step;
    if (sat) begin
        if (s > lim - 1) begin
            s = lim - 1;
        end else if (s < -lim) begin
            s = -lim;
        end
    end else begin
        s = ((s + lim) % (2 * lim) + 2 * lim) % (2 * lim) - lim;   // Modulo 2**WM_BITW.
    end
    return weight_t'(s);
endfunction

function automatic void model_reset();
    for (int r = 0; r < WM_DEPTH; r++) begin
        for (int l = 0; l < WM_WIDTH; l++) begin
            model_mem[r][l] = '0;
        end
    end
    model_sat   = 1'b0;
    model_lock  = '0;
    model_drops = 0;
    exp_q.delete();
endfunction

// Applied once for each command that transfers at the top-level ports.
function automatic void model_apply(wm_op_e op, logic [WM_WIDX_W-1:0] w,
                                    logic [WM_DIDX_W-1:0] d, logic [WM_DATA_W-1:0] data);
    exp_rsp_t e;
    if ((op != OP_READ) && model_lock[d]) begin
        model_drops++;
    end else if (op == OP_LOAD) begin
        model_mem[d][w] = weight_t'(data[WM_BITW-1:0]);
    end else if (op == OP_INCR) begin
        for (int l = 0; l < WM_WIDTH; l++) begin
            model_mem[d][l] = incr_value(model_mem[d][l], step_of(data, l), model_sat);
        end
    end else begin
        e.data  = model_mem[d][w];
        e.w_idx = w;
        e.d_idx = d;
        exp_q.push_back(e);
    end
endfunction

`endif

/* wm_tb.sv */
`timescale 1ns/1ps

module wm_tb;

    import wm_pkg::*;

    `include "wm_tb_model.svh"

    localparam int N_CELLS     = WM_DEPTH * WM_WIDTH;
    localparam int N_LOAD_RD   = 2 * N_CELLS;
    localparam int N_WRAP      = WM_WIDTH + 1 + WM_WIDTH + 24 + 64;
    localparam int N_SAT       = 2 * WM_WIDTH + 16 + 2 * WM_WIDTH;
    localparam int N_LOCK      = 48 + 64;
    localparam int N_MIXED     = 200;
    localparam int N_CMDS      = N_LOAD_RD + N_WRAP + N_SAT + N_LOCK + N_MIXED;
    localparam int CYCLE_LIMIT = 4 * N_CMDS + 16 + 500;

    logic                    clk;
    logic                    rst_n;
    logic                    cmd_valid;
    logic                    cmd_ready;
    wm_op_e                  cmd_op;
    logic [WM_WIDX_W-1:0]    cmd_w_idx;
    logic [WM_DIDX_W-1:0]    cmd_d_idx;
    logic [WM_DATA_W-1:0]    cmd_data;
    logic                    rsp_valid;
    logic                    rsp_ready;
    weight_t                 rsp_data;
    logic [WM_WIDX_W-1:0]    rsp_w_idx;
    logic [WM_DIDX_W-1:0]    rsp_d_idx;
    logic                    cfg_we;
    logic                    cfg_sat;
    logic [WM_DEPTH-1:0]     cfg_lock;
    logic [DROP_CNT_W-1:0]   drop_count;

    integer seed;
    int     mismatch_errors;
    int     other_errors;
    int     cycles;

    wm_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_op     (cmd_op),
        .cmd_w_idx  (cmd_w_idx),
        .cmd_d_idx  (cmd_d_idx),
        .cmd_data   (cmd_data),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_data   (rsp_data),
        .rsp_w_idx  (rsp_w_idx),
        .rsp_d_idx  (rsp_d_idx),
        .cfg_we     (cfg_we),
        .cfg_sat    (cfg_sat),
        .cfg_lock   (cfg_lock),
        .drop_count (drop_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks and random helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_weight(string name, weight_t exp, weight_t act);
        if (act !== exp) begin
            mismatch_errors++;
            $display("Mismatch at %0t: %s expected %0d, actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_index(string name, logic [WM_WIDX_W-1:0] exp,
                               logic [WM_WIDX_W-1:0] act);
        if (act !== exp) begin
            mismatch_errors++;
            $display("Mismatch at %0t: %s expected %0d, actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_count(string name, logic [DROP_CNT_W-1:0] exp,
                               logic [DROP_CNT_W-1:0] act);
        if (act !== exp) begin
            mismatch_errors++;
            $display("Mismatch at %0t: %s expected %0d, actual %0d", $time, name, exp, act);
        end
    endtask

    function automatic int rand_below(int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    function automatic logic [WM_DATA_W-1:0] rand_data();
        return $random(seed);
    endfunction

    task automatic check_response();
        exp_rsp_t e;
        if (exp_q.size() == 0) begin
            other_errors++;
            $display("At %0t a response arrived while no READ was outstanding", $time);
        end else begin
            e = exp_q.pop_front();
            check_weight("rsp_data", e.data, rsp_data);
            check_index("rsp_w_idx", e.w_idx, rsp_w_idx);
            check_index("rsp_d_idx", e.d_idx, rsp_d_idx);
        end
    endtask

    // Handshakes are stable at the falling edge, half a cycle before they transfer.
    always @(negedge clk) begin
        if (rst_n && rsp_valid && rsp_ready) begin
            check_response();
        end
        if (rst_n && cmd_valid && cmd_ready) begin
            model_apply(cmd_op, cmd_w_idx, cmd_d_idx, cmd_data);
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            #2;
            rsp_ready = (rand_below(4) != 0);      // Stall about a quarter of the time.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Command driving
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic send_cmd(wm_op_e op, int w, int d, logic [WM_DATA_W-1:0] data);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_w_idx = WM_WIDX_W'(w);
        cmd_d_idx = WM_DIDX_W'(d);
        cmd_data  = data;
        @(negedge clk);
        while (!cmd_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        cmd_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || rsp_valid) && waited < 64) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("At %0t %0d READ responses never arrived", $time, exp_q.size());
            exp_q.delete();
        end
        repeat (3) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic set_config(logic sat, logic [WM_DEPTH-1:0] lock);
        drain();
        cfg_we   = 1'b1;
        cfg_sat  = sat;
        cfg_lock = lock;
        @(posedge clk);
        #2;
        cfg_we     = 1'b0;
        model_sat  = sat;
        model_lock = lock;
    endtask

    task automatic load_readback();
        int order [N_CELLS];
        int j;
        int t;
        for (int r = 0; r < WM_DEPTH; r++) begin
            for (int l = 0; l < WM_WIDTH; l++) begin
                send_cmd(OP_LOAD, l, r, rand_data());
            end
        end
        for (int i = 0; i < N_CELLS; i++) begin
            order[i] = i;
        end
        for (int i = N_CELLS - 1; i > 0; i--) begin
            j        = rand_below(i + 1);
            t        = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        for (int i = 0; i < N_CELLS; i++) begin
            send_cmd(OP_READ, order[i] % WM_WIDTH, order[i] / WM_WIDTH, rand_data());
        end
        drain();
    endtask

    task automatic incr_wrap();
        int row;
        row = rand_below(WM_DEPTH);
        for (int l = 0; l < WM_WIDTH; l++) begin
            send_cmd(OP_LOAD, l, row, (l % 2 == 0) ? 'h7f : 'h80);
        end
        send_cmd(OP_INCR, 0, row, {(WM_WIDTH / 2){4'hd}});   // Even lanes +1, odd lanes -1.
        for (int l = 0; l < WM_WIDTH; l++) begin
            send_cmd(OP_READ, l, row, rand_data());
        end
        for (int i = 0; i < 24; i++) begin
            send_cmd(OP_INCR, rand_below(WM_WIDTH), rand_below(WM_DEPTH), rand_data());
        end
        for (int i = 0; i < 64; i++) begin
            send_cmd(OP_READ, rand_below(WM_WIDTH), rand_below(WM_DEPTH), rand_data());
        end
        drain();
    endtask

    task automatic incr_saturate();
        int                   hi_row;
        int                   lo_row;
        logic [WM_DATA_W-1:0] d;
        set_config(1'b1, '0);
        hi_row = rand_below(WM_DEPTH);
        lo_row = (hi_row + 1 + rand_below(WM_DEPTH - 1)) % WM_DEPTH;
        for (int l = 0; l < WM_WIDTH; l++) begin
            d = rand_data();
            d[WM_BITW-1:0] = WM_BITW'(127 - rand_below(4));
            send_cmd(OP_LOAD, l, hi_row, d);
            d = rand_data();
            d[WM_BITW-1:0] = WM_BITW'(-128 + rand_below(4));
            send_cmd(OP_LOAD, l, lo_row, d);
        end
        for (int i = 0; i < 8; i++) begin
            send_cmd(OP_INCR, 0, hi_row, rand_data() & {WM_WIDTH{2'b01}});   // Steps 0 or +1.
            send_cmd(OP_INCR, 0, lo_row, rand_data() | {WM_WIDTH{2'b10}});   // Steps -1 or -2.
        end
        for (int l = 0; l < WM_WIDTH; l++) begin
            send_cmd(OP_READ, l, hi_row, rand_data());
            send_cmd(OP_READ, l, lo_row, rand_data());
        end
        drain();
    endtask

    task automatic row_lock();
        logic [WM_DEPTH-1:0] lock;
        wm_op_e              op;
        lock = WM_DEPTH'(rand_data());
        if (lock == '0 || lock == '1) begin
            lock = WM_DEPTH'(8'h5a);
        end
        set_config(rand_below(2) == 1, lock);
        for (int i = 0; i < 48; i++) begin
            op = (rand_below(2) == 0) ? OP_LOAD : OP_INCR;
            send_cmd(op, rand_below(WM_WIDTH), rand_below(WM_DEPTH), rand_data());
        end
        for (int i = 0; i < 64; i++) begin
            send_cmd(OP_READ, rand_below(WM_WIDTH), rand_below(WM_DEPTH), rand_data());
        end
        drain();
        check_count("drop_count", DROP_CNT_W'(model_drops), drop_count);
    endtask

    task automatic mixed_traffic();
        int     k;
        wm_op_e op;
        set_config(1'b0, '0);
        for (int i = 0; i < N_MIXED; i++) begin
            k  = rand_below(20);
            op = (k < 10) ? OP_READ : (k < 17) ? OP_LOAD : OP_INCR;
            send_cmd(op, rand_below(WM_WIDTH), rand_below(WM_DEPTH), rand_data());
        end
        drain();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        seed            = 32'h445c;
        mismatch_errors = 0;
        other_errors    = 0;
        rst_n           = 1'b0;
        cmd_valid       = 1'b0;
        cmd_op          = OP_LOAD;
        cmd_w_idx       = '0;
        cmd_d_idx       = '0;
        cmd_data        = '0;
        rsp_ready       = 1'b1;
        cfg_we          = 1'b0;
        cfg_sat         = 1'b0;
        cfg_lock        = '0;
        model_reset();
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;

        load_readback();
        incr_wrap();
        incr_saturate();
        row_lock();
        mixed_traffic();
        check_count("drop_count", DROP_CNT_W'(model_drops), drop_count);

        $display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        other_errors++;
        $display("Timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* list.f */
+incdir+.
wm_pkg.sv
wm_cmd_if.sv
wm_cmd_front.sv
wm_mode_regs.sv
weight_update_alu.sv
weight_bank.sv
wm_top.sv
wm_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := wm_tb
FILELIST := list.f

SRCS     := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HDRS     := $(wildcard *.svh)
BIN      := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, a header or the file list changes.
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir
